/* design/eu_macros.svh */
// sizing of the event unit; the SoC FIFO depth must be a power of two and line indices below 32
`ifndef EU_MACROS_SVH
`define EU_MACROS_SVH

`default_nettype none

// cluster size and software event count
`define EU_NB_CORES 4
`define EU_NB_SW_EVT 8

// SoC peripheral event FIFO
`define EU_SOC_FIFO_DEPTH 4
`define EU_EVNT_WIDTH 8

// fixed positions on the per-core event line vector
`define EU_LINE_BARR 8
`define EU_LINE_SOC 9

// command payload width
`define EU_CMD_W 32

`default_nettype wire

`endif

/* design/eu_pkg.sv */
// shared types of the event unit; widths come from eu_macros.svh, op encodings are fixed
`include "eu_macros.svh"
`default_nettype none

package eu_pkg;

  // one bit per core, used for targets, arrivals and pops
  typedef logic [`EU_NB_CORES-1:0] core_mask_t;

  // one bit per software event
  typedef logic [`EU_NB_SW_EVT-1:0] sw_evt_t;

  // event lines seen by one core: sw events low, then barrier and SoC pending
  typedef logic [31:0] evt_lines_t;

  typedef logic [`EU_EVNT_WIDTH-1:0] soc_evt_id_t;

  typedef logic [`EU_CMD_W-1:0] cmd_data_t;

  typedef enum logic [2:0] {
    OP_MASK    = 3'd0,
    OP_TRIG    = 3'd1,
    OP_WAIT    = 3'd2,
    OP_BARRIER = 3'd3,
    OP_SOC_POP = 3'd4
  } eu_op_t;

  typedef enum logic {
    ST_RUN   = 1'b0,
    ST_SLEEP = 1'b1
  } core_state_t;

endpackage

`default_nettype wire

/* design/eu_trig_if.sv */
// per-core link to the shared event logic; the core side registers its outputs
`default_nettype none

interface eu_trig_if;
  import eu_pkg::*;

  // requests from the core
  sw_evt_t    sw_trig;
  core_mask_t sw_target;
  logic       barr_arrive;
  logic       soc_pop;

  // event lines back to the core
  evt_lines_t lines;

  modport core (
    output sw_trig, sw_target, barr_arrive, soc_pop,
    input  lines
  );

  modport fabric (
    input  sw_trig, sw_target, barr_arrive, soc_pop,
    output lines
  );

endinterface

`default_nettype wire

/* design/sw_evt_router.sv */
// combinational sw event routing; a core may target itself, triggers last one cycle
`include "eu_macros.svh"
`default_nettype none

module sw_evt_router (
  eu_trig_if.fabric                        trig [`EU_NB_CORES-1:0],
  output eu_pkg::sw_evt_t [`EU_NB_CORES-1:0] sw_lines_o
);
  import eu_pkg::*;

  sw_evt_t    [`EU_NB_CORES-1:0] trig_evt;
  core_mask_t [`EU_NB_CORES-1:0] trig_target;

  // flatten the interface array so the loops below can index it freely
  for (genvar s = 0; s < `EU_NB_CORES; s++) begin : g_sender
    assign trig_evt[s]    = trig[s].sw_trig;
    assign trig_target[s] = trig[s].sw_target;
  end

  // receiver r sees the OR of every sender that has r in its target set
  always_comb begin
    sw_lines_o = '0;
    for (int r = 0; r < `EU_NB_CORES; r++) begin
      for (int s = 0; s < `EU_NB_CORES; s++) begin
        if (trig_target[s][r]) begin
          sw_lines_o[r] = sw_lines_o[r] | trig_evt[s];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/hw_barrier_unit.sv */
// single all-core barrier; a second arrival from the same core before release is absorbed
`include "eu_macros.svh"
`default_nettype none

module hw_barrier_unit (
  input  logic               clk_i,
  input  logic               reset_i,
  input  eu_pkg::core_mask_t arrive_i,
  output logic               barr_evt_o
);
  import eu_pkg::*;

  core_mask_t arrived_q;
  core_mask_t arrived_all;
  logic       complete;

  // set of cores including the ones arriving in this cycle
  assign arrived_all = arrived_q | arrive_i;
  assign complete    = &arrived_all;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      arrived_q  <= '0;
      barr_evt_o <= 1'b0;
    end else begin
      barr_evt_o <= complete;
      if (complete) begin
        // last core in, release and start a fresh round
        arrived_q <= '0;
      end else begin
        arrived_q <= arrived_all;
      end
    end
  end

endmodule

`default_nettype wire

/* design/soc_periph_fifo.sv */
// SoC event id FIFO with valid/ready input; one pop per cycle, a pop on empty is ignored
`include "eu_macros.svh"
`default_nettype none

module soc_periph_fifo (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                valid_i,
  output logic                ready_o,
  input  eu_pkg::soc_evt_id_t data_i,
  input  eu_pkg::core_mask_t  pop_i,
  output eu_pkg::soc_evt_id_t head_o,
  output logic                pending_o
);
  import eu_pkg::*;

  localparam int PTR_W = $clog2(`EU_SOC_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`EU_SOC_FIFO_DEPTH + 1);

  soc_evt_id_t      mem [`EU_SOC_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign ready_o   = count_q < CNT_W'(`EU_SOC_FIFO_DEPTH);
  assign pending_o = count_q != '0;
  assign push      = valid_i && ready_o;
  // any requesting core counts as one pop, the lowest index one is served
  assign pop       = (|pop_i) && pending_o;

  assign head_o = pending_o ? mem[rd_ptr_q] : '0;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap naturally with a power of two depth
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/event_unit_core.sv */
// per-core event unit; commands are ignored state-wise while asleep, the SoC line is a level
`include "eu_macros.svh"
`default_nettype none

module event_unit_core (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               cmd_valid_i,
  input  eu_pkg::eu_op_t     cmd_op_i,
  input  eu_pkg::cmd_data_t  cmd_data_i,
  eu_trig_if.core            trig,
  output logic               clock_en_o,
  output logic               wake_o,
  output eu_pkg::evt_lines_t wake_events_o
);
  import eu_pkg::*;

  localparam evt_lines_t SOC_BIT = evt_lines_t'(1) << `EU_LINE_SOC;

  core_state_t state_q;
  evt_lines_t  mask_q;
  evt_lines_t  sticky_q;
  evt_lines_t  pending;
  evt_lines_t  matched;
  logic        is_mask;
  logic        is_trig;
  logic        is_wait;
  logic        is_barr;
  logic        is_pop;

  // command decode
  assign is_mask = cmd_valid_i && (cmd_op_i == OP_MASK);
  assign is_trig = cmd_valid_i && (cmd_op_i == OP_TRIG);
  assign is_wait = cmd_valid_i && (cmd_op_i == OP_WAIT);
  assign is_barr = cmd_valid_i && (cmd_op_i == OP_BARRIER);
  assign is_pop  = cmd_valid_i && (cmd_op_i == OP_SOC_POP);

  // requests toward the shared logic, one cycle after the command
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      trig.sw_trig     <= '0;
      trig.sw_target   <= '0;
      trig.barr_arrive <= 1'b0;
      trig.soc_pop     <= 1'b0;
    end else begin
      trig.sw_trig     <= is_trig ? cmd_data_i[`EU_NB_SW_EVT-1:0] : '0;
      trig.sw_target   <= is_trig ? cmd_data_i[16 +: `EU_NB_CORES] : '0;
      trig.barr_arrive <= is_barr;
      trig.soc_pop     <= is_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_q <= '0;
    end else if (is_mask) begin
      mask_q <= cmd_data_i;
    end
  end

  // SoC pending is taken live from the FIFO, everything else is sticky
  assign pending = sticky_q | (trig.lines & SOC_BIT);
  assign matched = pending & mask_q;

  assign wake_o        = (state_q == ST_SLEEP) && (matched != '0);
  assign wake_events_o = wake_o ? matched : '0;
  assign clock_en_o    = (state_q == ST_RUN);

  // matched bits are consumed on wake, new arrivals in the same cycle survive
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sticky_q <= '0;
    end else begin
      sticky_q <= (sticky_q & ~wake_events_o) | (trig.lines & ~SOC_BIT);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_RUN;
    end else begin
      case (state_q)
        ST_RUN: begin
          if (is_wait) begin
            state_q <= ST_SLEEP;
          end
        end
        ST_SLEEP: begin
          if (wake_o) begin
            state_q <= ST_RUN;
          end
        end
        default: state_q <= ST_RUN;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/event_unit_top.sv */
// event unit top level; no bus access, commands arrive on plain per-core ports every cycle
`include "eu_macros.svh"
`default_nettype none

module event_unit_top (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  eu_pkg::core_mask_t                       cmd_valid_i,
  input  eu_pkg::eu_op_t     [`EU_NB_CORES-1:0]    cmd_op_i,
  input  eu_pkg::cmd_data_t  [`EU_NB_CORES-1:0]    cmd_data_i,
  output eu_pkg::core_mask_t                       core_clock_en_o,
  output eu_pkg::core_mask_t                       wake_o,
  output eu_pkg::evt_lines_t [`EU_NB_CORES-1:0]    wake_events_o,
  input  logic                                     soc_evt_valid_i,
  output logic                                     soc_evt_ready_o,
  input  eu_pkg::soc_evt_id_t                      soc_evt_data_i,
  output eu_pkg::soc_evt_id_t                      soc_head_o
);
  import eu_pkg::*;

  sw_evt_t    [`EU_NB_CORES-1:0] sw_lines;
  core_mask_t                    barr_arrive;
  core_mask_t                    soc_pop;
  logic                          barr_evt;
  logic                          soc_pending;

  eu_trig_if trig_if [`EU_NB_CORES-1:0] ();

  for (genvar i = 0; i < `EU_NB_CORES; i++) begin : g_core
    event_unit_core event_unit_core_inst (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .cmd_valid_i   (cmd_valid_i[i]),
      .cmd_op_i      (cmd_op_i[i]),
      .cmd_data_i    (cmd_data_i[i]),
      .trig          (trig_if[i]),
      .clock_en_o    (core_clock_en_o[i]),
      .wake_o        (wake_o[i]),
      .wake_events_o (wake_events_o[i])
    );

    assign barr_arrive[i] = trig_if[i].barr_arrive;
    assign soc_pop[i]     = trig_if[i].soc_pop;

    // event line map, same barrier and SoC lines for every core
    assign trig_if[i].lines = evt_lines_t'(sw_lines[i])
                            | (evt_lines_t'(barr_evt) << `EU_LINE_BARR)
                            | (evt_lines_t'(soc_pending) << `EU_LINE_SOC);
  end

  sw_evt_router sw_evt_router_inst (
    .trig       (trig_if),
    .sw_lines_o (sw_lines)
  );

  hw_barrier_unit hw_barrier_unit_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .arrive_i   (barr_arrive),
    .barr_evt_o (barr_evt)
  );

  soc_periph_fifo soc_periph_fifo_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .valid_i   (soc_evt_valid_i),
    .ready_o   (soc_evt_ready_o),
    .data_i    (soc_evt_data_i),
    .pop_i     (soc_pop),
    .head_o    (soc_head_o),
    .pending_o (soc_pending)
  );

endmodule

`default_nettype wire

/* bench/event_unit_top_assert.sv */
// assertions bound into event_unit_top; the FIFO fill level is rebuilt from the handshake and pops
`include "eu_macros.svh"
`default_nettype none

module event_unit_top_assert (
  input logic               clk_i,
  input logic               reset_i,
  input eu_pkg::core_mask_t wake_i,
  input eu_pkg::core_mask_t core_clock_en_i,
  input logic               soc_evt_valid_i,
  input logic               soc_evt_ready_i,
  input eu_pkg::core_mask_t soc_pop_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CNT_W = $clog2(`EU_SOC_FIFO_DEPTH + 1);

  logic [CNT_W-1:0] held_q;
  logic             push;
  logic             pop;

  assign push = soc_evt_valid_i && soc_evt_ready_i;
  // several popping cores still remove one entry
  assign pop  = (|soc_pop_i) && (held_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      held_q <= '0;
    end else if (push && !pop) begin
      held_q <= held_q + CNT_W'(1);
    end else if (pop && !push) begin
      held_q <= held_q - CNT_W'(1);
    end
  end

  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : g_core
    wake_restores_clock: assert property (
      @(posedge clk_i) disable iff (reset_i) wake_i[c] |=> core_clock_en_i[c]
    ) else $error("core %0d clock enable low in the cycle after wake", c);

    wake_single_cycle: assert property (
      @(posedge clk_i) disable iff (reset_i) wake_i[c] |=> !wake_i[c]
    ) else $error("core %0d wake high on two consecutive cycles", c);
  end

  ready_low_when_full: assert property (
    @(posedge clk_i) disable iff (reset_i)
      !soc_evt_ready_i |-> held_q == CNT_W'(`EU_SOC_FIFO_DEPTH)
  ) else $error("SoC ready low with %0d entries held", held_q);

endmodule

bind event_unit_top event_unit_top_assert event_unit_top_assert_inst (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .wake_i          (wake_o),
  .core_clock_en_i (core_clock_en_o),
  .soc_evt_valid_i (soc_evt_valid_i),
  .soc_evt_ready_i (soc_evt_ready_o),
  .soc_pop_i       (soc_pop)
);

`default_nettype wire

/* bench/event_unit_top_tb.sv */
// testbench for event_unit_top; assumes 4 cores, the line map of eu_macros.svh and a FIFO depth of 4
`include "eu_macros.svh"
`default_nettype none

module event_unit_top_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import eu_pkg::*;

  localparam int NB = `EU_NB_CORES;
  localparam int QUIET_CYCLES = 20;
  localparam int WAKE_TIMEOUT = 50;

  typedef enum logic [2:0] {CHK_NONE, CHK_WAKE, CHK_QUIET, CHK_CLKEN, CHK_SOC} chk_t;

  // exp_a is the wake, clock enable or head value, exp_b the wake events or ready
  typedef struct packed {
    core_mask_t         valid;
    eu_op_t [NB-1:0]    op;
    cmd_data_t [NB-1:0] data;
    logic               soc_valid;
    soc_evt_id_t        soc_data;
    chk_t               chk;
    logic [31:0]        exp_a;
    logic [31:0]        exp_b;
  } step_t;

  logic                clk_i = 1'b0;
  logic                reset_i;
  core_mask_t          cmd_valid_i;
  eu_op_t [NB-1:0]     cmd_op_i;
  cmd_data_t [NB-1:0]  cmd_data_i;
  core_mask_t          core_clock_en_o;
  core_mask_t          wake_o;
  evt_lines_t [NB-1:0] wake_events_o;
  logic                soc_evt_valid_i;
  logic                soc_evt_ready_o;
  soc_evt_id_t         soc_evt_data_i;
  soc_evt_id_t         soc_head_o;
  integer              seed = 32'h0460_3228;
  step_t               steps [$];

  event_unit_top event_unit_top_inst (.*);

  always #5 clk_i = ~clk_i;

  task automatic fail_now();
    $display("STATUS: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      fail_now();
    end
  endtask

  function automatic step_t cmds(core_mask_t cores, eu_op_t op, cmd_data_t data);
    step_t s;
    int    c;
    s = '0;
    for (c = 0; c < NB; c++) begin
      if (cores[c]) begin
        s.valid[c] = 1'b1;
        s.op[c]    = op;
        s.data[c]  = data;
      end
    end
    return s;
  endfunction

  function automatic step_t soc_push(soc_evt_id_t id);
    step_t s;
    s = '0;
    s.soc_valid = 1'b1;
    s.soc_data  = id;
    return s;
  endfunction

  // events in bits 7..0, target cores in bits 19..16
  function automatic cmd_data_t trig_data(core_mask_t target, int evt);
    return (cmd_data_t'(target) << 16) | (cmd_data_t'(1) << evt);
  endfunction

  task automatic add(step_t s, chk_t kind, logic [31:0] exp_a, logic [31:0] exp_b);
    s.chk   = kind;
    s.exp_a = exp_a;
    s.exp_b = exp_b;
    steps.push_back(s);
  endtask

  task automatic wait_wake(core_mask_t cores, evt_lines_t evts);
    int n;
    int c;
    for (n = 0; n < WAKE_TIMEOUT && wake_o == '0; n++) begin
      @(negedge clk_i);
    end
    if (wake_o == '0) begin
      $display("timeout at %0t: no core woke up", $time);
      fail_now();
    end else begin
      check(32'(wake_o), 32'(cores), "wake mask");
      for (c = 0; c < NB; c++) begin
        if (cores[c]) begin
          check(wake_events_o[c], evts, "wake events");
        end
      end
      @(negedge clk_i);
      check(32'(core_clock_en_o & cores), 32'(cores), "clock enable after wake");
    end
  endtask

  task automatic stay_quiet();
    int n;
    for (n = 0; n < QUIET_CYCLES; n++) begin
      check(32'(wake_o), 32'd0, "wake without an enabled event");
      @(negedge clk_i);
    end
  endtask

  // called on a falling edge, runs one command cycle and then the row's check
  task automatic apply(step_t s);
    logic accepted;
    cmd_valid_i = s.valid;
    cmd_op_i    = s.op;
    cmd_data_i  = s.data;
    if (s.soc_valid) begin
      soc_evt_valid_i = 1'b1;
      soc_evt_data_i  = s.soc_data;
    end
    // ready only moves on a rising edge, so this is what the FIFO samples
    accepted = soc_evt_valid_i && soc_evt_ready_o;
    @(negedge clk_i);
    cmd_valid_i = '0;
    if (accepted) begin
      soc_evt_valid_i = 1'b0;
    end
    case (s.chk)
      CHK_WAKE:  wait_wake(core_mask_t'(s.exp_a), s.exp_b);
      CHK_QUIET: stay_quiet();
      CHK_CLKEN: check(32'(core_clock_en_o), s.exp_a, "clock enable");
      CHK_SOC: begin
        check(32'(soc_head_o), s.exp_a, "SoC head");
        check(32'(soc_evt_ready_o), s.exp_b, "SoC ready");
      end
      default: ;
    endcase
  endtask

  initial begin
    int e;
    int e2;
    int c;
    reset_i         = 1'b1;
    cmd_valid_i     = '0;
    cmd_op_i        = '0;
    cmd_data_i      = '0;
    soc_evt_valid_i = 1'b0;
    soc_evt_data_i  = '0;
    e  = $unsigned($random(seed)) % `EU_NB_SW_EVT;
    e2 = $unsigned($random(seed)) % `EU_NB_SW_EVT;

    // core 1 wakes core 0 through a sw event
    add(cmds(4'b0001, OP_MASK, 32'(1) << e), CHK_NONE, 0, 0);
    add(cmds(4'b0001, OP_WAIT, '0), CHK_CLKEN, 32'b1110, 0);
    add(cmds(4'b0010, OP_TRIG, trig_data(4'b0001, e)), CHK_WAKE, 32'b0001, 32'(1) << e);
    // a target set without core 2 leaves it asleep
    add(cmds(4'b0010, OP_TRIG, trig_data(4'b1011, e2)), CHK_NONE, 0, 0);
    add(cmds(4'b0100, OP_MASK, 32'(1) << e2), CHK_NONE, 0, 0);
    add(cmds(4'b0100, OP_WAIT, '0), CHK_QUIET, 0, 0);
    add(cmds(4'b0010, OP_TRIG, trig_data(4'b0100, e2)), CHK_WAKE, 32'b0100, 32'(1) << e2);
    // staggered barrier, nobody wakes before the last arrival
    add(cmds(4'b1111, OP_MASK, 32'(1) << `EU_LINE_BARR), CHK_NONE, 0, 0);
    for (c = 0; c < NB; c++) begin
      add(cmds(core_mask_t'(1 << c), OP_BARRIER, '0), CHK_NONE, 0, 0);
      add(cmds(core_mask_t'(1 << c), OP_WAIT, '0), (c == NB - 1) ? CHK_WAKE : CHK_QUIET,
          32'((1 << NB) - 1), 32'(1) << `EU_LINE_BARR);
    end
    // SoC FIFO fill, back-pressure and pops
    add(cmds(4'b0001, OP_MASK, 32'(1) << `EU_LINE_SOC), CHK_SOC, 0, 1);
    add(cmds(4'b0001, OP_WAIT, '0), CHK_QUIET, 0, 0);
    add(soc_push(8'hA1), CHK_WAKE, 32'b0001, 32'(1) << `EU_LINE_SOC);
    add(soc_push(8'hB2), CHK_NONE, 0, 0);
    add(soc_push(8'hC3), CHK_NONE, 0, 0);
    add(soc_push(8'hD4), CHK_SOC, 8'hA1, 0);
    add(soc_push(8'hE5), CHK_SOC, 8'hA1, 0);
    add(cmds(4'b0001, OP_SOC_POP, '0), CHK_NONE, 0, 0);
    add(cmds(4'b1110, OP_SOC_POP, '0), CHK_SOC, 8'hB2, 1);
    add(cmds(4'b0001, OP_SOC_POP, '0), CHK_SOC, 8'hC3, 1);
    add(cmds(4'b0001, OP_SOC_POP, '0), CHK_SOC, 8'hD4, 1);
    add(cmds(4'b0001, OP_SOC_POP, '0), CHK_SOC, 8'hE5, 1);
    add('0, CHK_SOC, 0, 1);

    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    check(32'(core_clock_en_o), 32'((1 << NB) - 1), "clock enable after reset");
    check(32'(wake_o), 32'd0, "wake after reset");
    check(32'(soc_evt_ready_o), 32'd1, "SoC ready after reset");
    foreach (steps[i]) begin
      apply(steps[i]);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* event_unit_top.f */
+incdir+design
design/eu_pkg.sv
design/eu_trig_if.sv
design/sw_evt_router.sv
design/hw_barrier_unit.sv
design/soc_periph_fifo.sv
design/event_unit_core.sv
design/event_unit_top.sv
bench/event_unit_top_assert.sv
bench/event_unit_top_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module event_unit_top_tb -f event_unit_top.f &&
  ./obj_dir/Vevent_unit_top_tb || exit 1
